/* dv/gat_attn_testdata.txt */
# A s_lo s_hi n_lo n_hi = attention halves | W addr lo hi = row, elements 0-7 lo, 8-15 hi
# R base count mul_lo mul_hi = rows from address | E count coefs | S base nodes stall
A 20 -10 50 100
W 0 400 100
W 1 100 -50
W 2 -1000 -200
W 3 1500 1000
W 4 0 30
W 5 -300 200
W 6 300 400
W 7 1000 0
R 16 40 32 -16
# five nodes, self-loop first, with a negative and a saturated sum
E 5 144 27 0 255 39
S 0 5 0
# second subgraph straight after, new source row
E 3 0 183 164
S 5 3 0
# new attention vector on the same five nodes
A 15 -15 40 16
E 5 86 30 0 255 19
S 0 5 0
# forty nodes with the FIFO held
E 10 109 113 117 121 125 129 133 137 141 145
E 10 149 153 157 161 165 169 173 177 181 185
E 10 189 193 197 201 205 209 213 217 221 225
E 10 229 233 237 241 245 249 253 255 255 255
S 16 40 1

/* dv/tb_gat_attn.sv */
// gat attention testbench
// replays the testdata records against the attention subsystem and checks
// every coefficient in order against the attention rule
`timescale 1ns/1ps
`default_nettype none

module tb_gat_attn;
  import gat_attn_pkg::*;

  localparam int NF       = 16;
  localparam int WH_DEPTH = 64;
  localparam int FF_DEPTH = 16;
  localparam int AW       = $clog2(WH_DEPTH);
  localparam int TIMEOUT  = 2000;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               a_vld_i;
  attn_w_t [2*NF-1:0] a_i;
  logic               wh_wr_en_i;
  logic [AW-1:0]      wh_wr_addr_i;
  wh_elem_t [NF-1:0]  wh_wr_row_i;
  logic               start_i;
  logic [AW-1:0]      base_addr_i;
  num_node_t          num_node_i;
  logic               busy_o;
  logic               coef_rd_i;
  coef_t              coef_o;
  logic               coef_empty_o;

  // reference copies of weights and rows
  int          a_m [2*NF];
  int          wh_m [WH_DEPTH][NF];
  coef_t       exp_q [$];
  int          file_q [$];
  logic        hold_rd;
  int          coef_errs;
  int          flag_errs;
  int          other_errs;

  gat_attn_top #(
    .NUM_FEATURE_OUT(NF),
    .WH_DEPTH(WH_DEPTH),
    .COEF_FF_DEPTH(FF_DEPTH)
  ) dut0 (
    .clk(clk),
    .rst_n(rst_n),
    .a_vld_i(a_vld_i),
    .a_i(a_i),
    .wh_wr_en_i(wh_wr_en_i),
    .wh_wr_addr_i(wh_wr_addr_i),
    .wh_wr_row_i(wh_wr_row_i),
    .start_i(start_i),
    .base_addr_i(base_addr_i),
    .num_node_i(num_node_i),
    .busy_o(busy_o),
    .coef_rd_i(coef_rd_i),
    .coef_o(coef_o),
    .coef_empty_o(coef_empty_o)
  );

  always #4 clk = ~clk;

  // ========================================
  // checks and reference rule
  // ========================================
  task automatic compare_coef(input string name, input coef_t exp_v, input coef_t act_v);
    if (exp_v !== act_v) begin
      coef_errs++;
      $display("mismatch %s: expected 0x%02h actual 0x%02h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      flag_errs++;
      $display("mismatch %s: expected 0x%0h actual 0x%0h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  // ReLU of S plus N with shift and saturation
  function automatic coef_t coef_rule(input int src, input int row);
    int s;
    int n;
    int t;
    s = 0;
    n = 0;
    for (int k = 0; k < NF; k++) begin
      s += a_m[k] * wh_m[src][k];
      n += a_m[NF+k] * wh_m[row][k];
    end
    t = s + n;
    if (t < 0) begin
      return '0;
    end
    t = t >>> COEF_SHIFT;
    if (t > 255) begin
      return coef_t'(255);
    end
    return coef_t'(t);
  endfunction

  // ========================================
  // bounded waits
  // ========================================
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy_o && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (busy_o) begin
      other_errs++;
      $display("timeout: busy_o still high after %0d cycles", TIMEOUT);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((busy_o || exp_q.size() != 0) && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (busy_o || exp_q.size() != 0) begin
      other_errs++;
      $display("timeout: %0d coefficients never arrived", exp_q.size());
    end
  endtask

  // ========================================
  // stimulus tasks
  // ========================================
  task automatic write_row(input int addr, input int lo, input int hi);
    @(negedge clk);
    wh_wr_en_i   = 1'b1;
    wh_wr_addr_i = AW'(addr);
    for (int k = 0; k < NF; k++) begin
      wh_m[addr][k]  = int'(wh_elem_t'((k < NF/2) ? lo : hi));
      wh_wr_row_i[k] = wh_elem_t'(wh_m[addr][k]);
    end
    @(negedge clk);
    wh_wr_en_i = 1'b0;
  endtask

  // weights change only with the pipeline empty
  task automatic load_attn(input int s_lo, input int s_hi, input int n_lo, input int n_hi);
    wait_drain();
    @(negedge clk);
    a_vld_i = 1'b1;
    for (int k = 0; k < NF; k++) begin
      a_m[k]      = int'(attn_w_t'((k < NF/2) ? s_lo : s_hi));
      a_m[NF+k]   = int'(attn_w_t'((k < NF/2) ? n_lo : n_hi));
      a_i[k]      = attn_w_t'(a_m[k]);
      a_i[NF+k]   = attn_w_t'(a_m[NF+k]);
    end
    @(negedge clk);
    a_vld_i = 1'b0;
  endtask

  task automatic run_subgraph(input int base, input int nodes, input int stall);
    int    fv;
    coef_t rv;
    int    cycles;
    if (stall != 0) begin
      wait_drain();
      hold_rd = 1'b1;
    end
    wait_idle();
    for (int i = 0; i < nodes; i++) begin
      rv = coef_rule(base, (base + i) % WH_DEPTH);
      if (file_q.size() == 0) begin
        other_errs++;
        $display("testdata has no expected coefficient for node %0d at base %0d", i, base);
      end else begin
        fv = file_q.pop_front();
        compare_coef("testdata coef", rv, coef_t'(fv));
      end
      exp_q.push_back(rv);
    end
    start_i     = 1'b1;
    base_addr_i = AW'(base);
    num_node_i  = num_node_t'(nodes);
    @(negedge clk);
    start_i = 1'b0;
    compare_flag("busy_o", 1'b1, busy_o);
    if (stall != 0) begin
      cycles = 0;
      while (busy_o && cycles < TIMEOUT/2) begin
        @(negedge clk);
        cycles++;
      end
      if (!busy_o) begin
        other_errs++;
        $display("busy_o fell while the coefficient FIFO was not read");
      end
      compare_flag("coef_empty_o", 1'b0, coef_empty_o);
      hold_rd = 1'b0;
      wait_drain();
    end
  endtask

  // FIFO reader with random idle gaps
  initial begin
    int    gap;
    coef_t exp_v;
    coef_rd_i = 1'b0;
    gap = 0;
    forever begin
      @(negedge clk);
      coef_rd_i = 1'b0;
      if (gap > 0) begin
        gap--;
      end else if (rst_n && !hold_rd && !coef_empty_o) begin
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("coefficient 0x%02h arrived with none expected", coef_o);
        end else begin
          exp_v = exp_q.pop_front();
          compare_coef("coef_o", exp_v, coef_o);
        end
        coef_rd_i = 1'b1;
        gap = int'($urandom % 4);
      end
    end
  end

  // ========================================
  // record replay
  // ========================================
  initial begin
    int                fd;
    int                code;
    int                n;
    int                v;
    int                f [4];
    logic [7:0]        tag;
    logic [8*128-1:0]  line_buf;
    rst_n        = 1'b0;
    a_vld_i      = 1'b0;
    a_i          = '0;
    wh_wr_en_i   = 1'b0;
    wh_wr_addr_i = '0;
    wh_wr_row_i  = '0;
    start_i      = 1'b0;
    base_addr_i  = '0;
    num_node_i   = '0;
    hold_rd      = 1'b0;
    coef_errs    = 0;
    flag_errs    = 0;
    other_errs   = 0;
    void'($urandom(32'hc2e0_e0b3));
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compare_flag("coef_empty_o", 1'b1, coef_empty_o);
    compare_flag("busy_o", 1'b0, busy_o);
    fd = $fopen("dv/gat_attn_testdata.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open dv/gat_attn_testdata.txt");
    end else begin
      while ($fscanf(fd, " %c", tag) == 1) begin
        case (tag)
          "#": code = $fgets(line_buf, fd);
          "A": begin
            code = $fscanf(fd, "%d %d %d %d", f[0], f[1], f[2], f[3]);
            load_attn(f[0], f[1], f[2], f[3]);
          end
          "W": begin
            code = $fscanf(fd, "%d %d %d", f[0], f[1], f[2]);
            write_row(f[0], f[1], f[2]);
          end
          "R": begin
            code = $fscanf(fd, "%d %d %d %d", f[0], f[1], f[2], f[3]);
            for (int i = 0; i < f[1]; i++) begin
              write_row(f[0] + i, (f[0] + i) * f[2], (f[0] + i) * f[3]);
            end
          end
          "E": begin
            code = $fscanf(fd, "%d", n);
            for (int i = 0; i < n; i++) begin
              code = $fscanf(fd, "%d", v);
              file_q.push_back(v);
            end
          end
          "S": begin
            code = $fscanf(fd, "%d %d %d", f[0], f[1], f[2]);
            run_subgraph(f[0], f[1], f[2]);
          end
          default: begin
            other_errs++;
            $display("unknown record tag %c in testdata", tag);
          end
        endcase
      end
      $fclose(fd);
    end
    wait_drain();
    @(negedge clk);
    compare_flag("coef_empty_o", 1'b1, coef_empty_o);
    compare_flag("busy_o", 1'b0, busy_o);
    if (file_q.size() != 0) begin
      other_errs++;
      $display("%0d expected coefficients in testdata belong to no subgraph", file_q.size());
    end
    $display("errors: coef %0d flag %0d other %0d", coef_errs, flag_errs, other_errs);
    if (coef_errs + flag_errs + other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the gat attention testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_gat_attn \
  -f vlog.f --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see sim.log"
exit 1

/* source/attn_coef_pipe.sv */
// attention coefficient pipeline
// source and neighbour dot products through a registered adder tree,
// then ReLU, shift and saturation to one 8-bit coefficient per row
`timescale 1ns/1ps
`default_nettype none

module attn_coef_pipe #(
  parameter int NUM_FEATURE_OUT = 16
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           a_vld_i,
  input  gat_attn_pkg::attn_w_t [2*NUM_FEATURE_OUT-1:0]  a_i,
  wh_stream_if.receiver                                  wh_i,
  output gat_attn_pkg::coef_t                            coef_o,
  output logic                                           coef_wr_o
);
  import gat_attn_pkg::*;

  localparam int LVL = $clog2(NUM_FEATURE_OUT);
  // tree root is valid this many stages after the input register
  localparam int TOP = LVL + 1;

  attn_w_t [2*NUM_FEATURE_OUT-1:0] a_q;
  attn_w_t [NUM_FEATURE_OUT-1:0]   a_src;
  attn_w_t [NUM_FEATURE_OUT-1:0]   a_nbr;
  wh_elem_t [NUM_FEATURE_OUT-1:0]  row_q;

  // heap layout, leaves at N-1 .. 2N-2, root at 0
  dmvm_acc_t [2*NUM_FEATURE_OUT-2:0] src_t;
  dmvm_acc_t [2*NUM_FEATURE_OUT-2:0] nbr_t;

  logic [TOP:0] vld_sr;
  logic [TOP:0] src_sr;
  logic         open_q;
  dmvm_acc_t    s_q;
  dmvm_acc_t    s_cur;
  dmvm_acc_t    sum;
  dmvm_acc_t    scaled;
  coef_t        coef_d;

  // ========================================
  // attention vector
  // ========================================
  always_ff @(posedge clk) begin
    if (a_vld_i) begin
      a_q <= a_i;
    end
  end

  assign a_src = a_q[NUM_FEATURE_OUT-1:0];
  assign a_nbr = a_q[2*NUM_FEATURE_OUT-1:NUM_FEATURE_OUT];

  // ========================================
  // input register, products, adder tree
  // ========================================
  always_ff @(posedge clk) begin
    if (wh_i.vld) begin
      row_q <= wh_i.row;
    end
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      src_t[NUM_FEATURE_OUT-1+k] <= $signed(a_src[k]) * $signed(row_q[k]);
      nbr_t[NUM_FEATURE_OUT-1+k] <= $signed(a_nbr[k]) * $signed(row_q[k]);
    end
    for (int i = 0; i < NUM_FEATURE_OUT-1; i++) begin
      src_t[i] <= src_t[2*i+1] + src_t[2*i+2];
      nbr_t[i] <= nbr_t[2*i+1] + nbr_t[2*i+2];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr <= '0;
      src_sr <= '0;
      open_q <= 1'b0;
    end else begin
      vld_sr <= {vld_sr[TOP-1:0], wh_i.vld};
      src_sr <= {src_sr[TOP-1:0], wh_i.vld && wh_i.src_flag};
      // subgraph open from its source row up to its final row
      if (wh_i.vld && wh_i.last) begin
        open_q <= 1'b0;
      end else if (wh_i.vld && wh_i.src_flag) begin
        open_q <= 1'b1;
      end
    end
  end

  // ========================================
  // source hold, ReLU and saturation
  // ========================================
  always_ff @(posedge clk) begin
    if (src_sr[TOP]) begin
      s_q <= src_t[0];
    end
  end

  always_comb begin
    s_cur  = src_sr[TOP] ? src_t[0] : s_q;
    sum    = s_cur + nbr_t[0];
    scaled = sum >>> COEF_SHIFT;
    if (sum[$bits(dmvm_acc_t)-1]) begin
      coef_d = '0;
    end else if (|scaled[$bits(dmvm_acc_t)-1:DATA_WIDTH]) begin
      coef_d = '1;
    end else begin
      coef_d = coef_t'(scaled);
    end
  end

  always_ff @(posedge clk) begin
    coef_o <= coef_d;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_wr_o <= 1'b0;
    end else begin
      coef_wr_o <= vld_sr[TOP];
    end
  end

  // weights must stay stable for every row of an open subgraph
  a_no_reload: assert property (@(posedge clk) disable iff (!rst_n)
    a_vld_i |-> !(wh_i.vld || (|vld_sr) || open_q))
    else $error("attn_coef_pipe: attention vector loaded with rows in flight");

endmodule

`default_nettype wire

/* source/coef_fifo.sv */
// coefficient FIFO
// first-word fall-through buffer for coefficients, with a headroom flag
// that covers every row still inside the pipeline
`timescale 1ns/1ps
`default_nettype none

module coef_fifo #(
  parameter int COEF_FF_DEPTH = 16,
  parameter int PIPE_DEPTH    = 9
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr_i,
  input  gat_attn_pkg::coef_t din_i,
  input  logic                rd_i,
  output gat_attn_pkg::coef_t dout_o,
  output logic                empty_o,
  output logic                room_o
);
  import gat_attn_pkg::*;

  localparam int PTR_W = (COEF_FF_DEPTH > 1) ? $clog2(COEF_FF_DEPTH) : 1;
  localparam int CNT_W = $clog2(COEF_FF_DEPTH + 1);

  coef_t            mem [COEF_FF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_rd;

  assign do_rd   = rd_i && !empty_o;
  assign empty_o = (count_q == '0);
  assign dout_o  = mem[rd_ptr_q];
  assign room_o  = (count_q <= CNT_W'(COEF_FF_DEPTH - PIPE_DEPTH));

  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(COEF_FF_DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(COEF_FF_DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_i, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr_i |-> count_q != CNT_W'(COEF_FF_DEPTH))
    else $error("coef_fifo: write while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    rd_i |-> !empty_o)
    else $error("coef_fifo: read while empty");

endmodule

`default_nettype wire

/* source/gat_attn_pkg.sv */
// gat attention package
// shared widths, element types, scaling and scheduler states for the
// attention coefficient datapath
`default_nettype none

package gat_attn_pkg;

  // ========================================
  // widths and limits
  // ========================================
  localparam int DATA_WIDTH    = 8;
  localparam int WH_DATA_WIDTH = 12;
  localparam int MAX_NODES     = 168;

  // right shift of S plus N before saturation to 8 bits
  localparam int COEF_SHIFT    = 11;

  // ========================================
  // datapath types
  // ========================================
  typedef logic signed [DATA_WIDTH-1:0]    attn_w_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_elem_t;

  // 20-bit products, 16 of them, then S plus N
  typedef logic signed [25:0]              dmvm_acc_t;

  typedef logic [DATA_WIDTH-1:0]           coef_t;
  typedef logic [7:0]                      num_node_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_ROOM
  } pipe_state_e;

endpackage

`default_nettype wire

/* source/gat_attn_top.sv */
// gat attention top
// row buffer, subgraph scheduler, coefficient pipeline and output FIFO
`timescale 1ns/1ps
`default_nettype none

module gat_attn_top #(
  parameter int NUM_FEATURE_OUT = 16,
  parameter int WH_DEPTH        = 64,
  parameter int COEF_FF_DEPTH   = 16
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           a_vld_i,
  input  gat_attn_pkg::attn_w_t [2*NUM_FEATURE_OUT-1:0]  a_i,
  input  logic                                           wh_wr_en_i,
  input  logic [$clog2(WH_DEPTH)-1:0]                    wh_wr_addr_i,
  input  gat_attn_pkg::wh_elem_t [NUM_FEATURE_OUT-1:0]   wh_wr_row_i,
  input  logic                                           start_i,
  input  logic [$clog2(WH_DEPTH)-1:0]                    base_addr_i,
  input  gat_attn_pkg::num_node_t                        num_node_i,
  output logic                                           busy_o,
  input  logic                                           coef_rd_i,
  output gat_attn_pkg::coef_t                            coef_o,
  output logic                                           coef_empty_o
);
  import gat_attn_pkg::*;

  // pipeline latency plus the room flag and FIFO write turnaround
  localparam int PIPE_DEPTH = $clog2(NUM_FEATURE_OUT) + 3 + 2;

  logic                           rd_en;
  logic [$clog2(WH_DEPTH)-1:0]    rd_addr;
  wh_elem_t [NUM_FEATURE_OUT-1:0] rd_row;
  coef_t                          coef_data;
  logic                           coef_wr;
  logic                           room;

  wh_stream_if #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT)) wh_if ();

  wh_row_buffer #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT), .WH_DEPTH(WH_DEPTH)) u_row_buf (
    .clk(clk), .rst_n(rst_n),
    .wr_en_i(wh_wr_en_i), .wr_addr_i(wh_wr_addr_i), .wr_row_i(wh_wr_row_i),
    .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_row_o(rd_row)
  );

  subgraph_scheduler #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT), .WH_DEPTH(WH_DEPTH)) u_sched (
    .clk(clk), .rst_n(rst_n),
    .start_i(start_i), .base_addr_i(base_addr_i), .num_node_i(num_node_i),
    .room_i(room), .busy_o(busy_o),
    .rd_en_o(rd_en), .rd_addr_o(rd_addr), .rd_row_i(rd_row),
    .wh_o(wh_if.sender)
  );

  attn_coef_pipe #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT)) u_pipe (
    .clk(clk), .rst_n(rst_n),
    .a_vld_i(a_vld_i), .a_i(a_i),
    .wh_i(wh_if.receiver),
    .coef_o(coef_data), .coef_wr_o(coef_wr)
  );

  coef_fifo #(.COEF_FF_DEPTH(COEF_FF_DEPTH), .PIPE_DEPTH(PIPE_DEPTH)) u_coef_ff (
    .clk(clk), .rst_n(rst_n),
    .wr_i(coef_wr), .din_i(coef_data),
    .rd_i(coef_rd_i), .dout_o(coef_o),
    .empty_o(coef_empty_o), .room_o(room)
  );

endmodule

`default_nettype wire

/* source/subgraph_scheduler.sv */
// subgraph scheduler
// walks the rows of one subgraph in the row buffer, tags the source and
// final rows, and holds off while the coefficient FIFO lacks headroom
`timescale 1ns/1ps
`default_nettype none

module subgraph_scheduler #(
  parameter int NUM_FEATURE_OUT = 16,
  parameter int WH_DEPTH        = 64
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          start_i,
  input  logic [$clog2(WH_DEPTH)-1:0]                   base_addr_i,
  input  gat_attn_pkg::num_node_t                       num_node_i,
  input  logic                                          room_i,
  output logic                                          busy_o,
  output logic                                          rd_en_o,
  output logic [$clog2(WH_DEPTH)-1:0]                   rd_addr_o,
  input  gat_attn_pkg::wh_elem_t [NUM_FEATURE_OUT-1:0]  rd_row_i,
  wh_stream_if.sender                                   wh_o
);
  import gat_attn_pkg::*;

  localparam int ADDR_W = $clog2(WH_DEPTH);

  pipe_state_e       state_q;
  num_node_t         num_q;
  num_node_t         cnt_q;
  logic [ADDR_W-1:0] base_q;
  logic              issue;
  logic              issue_last;
  logic              vld_q;
  logic              src_q;
  logic              last_q;

  // one buffer read per cycle while the FIFO has room
  assign issue      = (state_q == ISSUE) && room_i;
  assign issue_last = issue && (cnt_q == num_q - 1'b1);

  assign rd_en_o   = issue;
  assign rd_addr_o = base_q + ADDR_W'(cnt_q);
  assign busy_o    = (state_q != IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      num_q   <= '0;
      cnt_q   <= '0;
      base_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            num_q   <= num_node_i;
            base_q  <= base_addr_i;
            cnt_q   <= '0;
            state_q <= ISSUE;
          end
        end
        ISSUE: begin
          if (!room_i) begin
            state_q <= WAIT_ROOM;
          end else if (issue_last) begin
            state_q <= IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        WAIT_ROOM: begin
          if (room_i) begin
            state_q <= ISSUE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ========================================
  // align control with buffer read data
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= 1'b0;
      src_q  <= 1'b0;
      last_q <= 1'b0;
    end else begin
      vld_q  <= issue;
      src_q  <= issue && (cnt_q == '0);
      last_q <= issue_last;
    end
  end

  assign wh_o.vld      = vld_q;
  assign wh_o.row      = rd_row_i;
  assign wh_o.src_flag = src_q;
  assign wh_o.last     = last_q;

  a_num_node: assert property (@(posedge clk) disable iff (!rst_n)
    (start_i && state_q == IDLE) |-> (num_node_i >= 1 && num_node_i <= MAX_NODES))
    else $error("subgraph_scheduler: node count out of range at start");

endmodule

`default_nettype wire

/* source/wh_row_buffer.sv */
// wh row buffer
// on-chip store of projected feature rows, one external write port and
// one read port with registered data
`timescale 1ns/1ps
`default_nettype none

module wh_row_buffer #(
  parameter int NUM_FEATURE_OUT = 16,
  parameter int WH_DEPTH        = 64
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          wr_en_i,
  input  logic [$clog2(WH_DEPTH)-1:0]                   wr_addr_i,
  input  gat_attn_pkg::wh_elem_t [NUM_FEATURE_OUT-1:0]  wr_row_i,
  input  logic                                          rd_en_i,
  input  logic [$clog2(WH_DEPTH)-1:0]                   rd_addr_i,
  output gat_attn_pkg::wh_elem_t [NUM_FEATURE_OUT-1:0]  rd_row_o
);
  import gat_attn_pkg::*;

  wh_elem_t [NUM_FEATURE_OUT-1:0] mem [WH_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_row_i;
    end
    // data valid the cycle after rd_en_i
    if (rd_en_i) begin
      rd_row_o <= mem[rd_addr_i];
    end
  end

  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_en_i |-> wr_addr_i < WH_DEPTH) and (rd_en_i |-> rd_addr_i < WH_DEPTH))
    else $error("wh_row_buffer: address beyond WH_DEPTH");

endmodule

`default_nettype wire

/* source/wh_stream_if.sv */
// wh row stream
// one projected feature row per strobe, scheduler to attention pipeline
`timescale 1ns/1ps
`default_nettype none

interface wh_stream_if #(
  parameter int NUM_FEATURE_OUT = 16
);
  import gat_attn_pkg::*;

  logic                                vld;
  wh_elem_t [NUM_FEATURE_OUT-1:0]      row;
  // first row of a subgraph carries the source node
  logic                                src_flag;
  logic                                last;

  modport sender   (output vld, row, src_flag, last);
  modport receiver (input  vld, row, src_flag, last);

endinterface

`default_nettype wire

/* vlog.f */
source/gat_attn_pkg.sv
source/wh_stream_if.sv
source/wh_row_buffer.sv
source/subgraph_scheduler.sv
source/attn_coef_pipe.sv
source/coef_fifo.sv
source/gat_attn_top.sv
dv/tb_gat_attn.sv
